// File: include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and instruction word width.
`define XLEN 32

// number of architectural registers, x0 included.
`define REG_NUM 32

`define RESET_PC 32'h0000_0000 // first fetch address after reset.

`endif

// File: src/core_pkg.sv
`include "core_config.svh"

package core_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`REG_NUM)-1:0] reg_addr_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2; // also the shamt of the shift immediates.
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm12;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_type_t;

	// one fetched word, seen through either field layout.
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} inst_t;

	typedef enum logic [2:0] {
		ALU_NOP,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [1:0] {
		SEL_NOP,
		SEL_LOGIC,
		SEL_SHIFT
	} alu_sel_e;

	localparam logic [6:0] OP_OP          = 7'b0110011;
	localparam logic [6:0] OP_OP_IMM      = 7'b0010011;
	localparam logic [2:0] FUNCT3_XOR     = 3'b100;
	localparam logic [2:0] FUNCT3_OR      = 3'b110;
	localparam logic [2:0] FUNCT3_AND     = 3'b111;
	localparam logic [2:0] FUNCT3_SLL     = 3'b001;
	localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
	localparam logic [6:0] FUNCT7_SRLI    = 7'b0000000;
	localparam logic [6:0] FUNCT7_SRAI    = 7'b0100000;

	typedef struct packed {
		alu_op_e   aluop;
		alu_sel_e  alusel;
		word_t     opv1;
		word_t     opv2;
		reg_addr_t reg_waddr;
		logic      we;
	} id_ex_t;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} reg_wr_t;

endpackage

// File: src/stage_if.sv
`timescale 1ns/1ns
`include "core_config.svh"

module stage_if (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic [`XLEN-1:0]   i_inst,
	output logic [`XLEN-1:0]   o_pc,
	output core_pkg::inst_t    o_id_inst
);

	import core_pkg::*;

	// the outside answers o_pc within the same cycle, so the word is
	// captured on the edge that also moves the pc on.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_pc      <= `RESET_PC;
			o_id_inst <= '0; // an all zero word decodes as a bubble.
		end else begin
			o_pc      <= o_pc + `XLEN'd4;
			o_id_inst <= inst_t'(i_inst);
		end
	end

endmodule

// File: src/stage_id.sv
`timescale 1ns/1ns

module stage_id (
	input  core_pkg::inst_t     i_inst,
	input  core_pkg::word_t     i_reg_data1,
	input  core_pkg::word_t     i_reg_data2,
	input  core_pkg::reg_wr_t   i_ex_fwd,
	input  core_pkg::reg_wr_t   i_mem_fwd,
	output logic                o_re1,
	output logic                o_re2,
	output core_pkg::reg_addr_t o_reg_addr1,
	output core_pkg::reg_addr_t o_reg_addr2,
	output core_pkg::id_ex_t    o_id_ex
);

	import core_pkg::*;

	alu_op_e  aluop;
	alu_sel_e alusel;
	word_t    imm;
	word_t    logic_imm;
	word_t    shift_imm;
	logic     we;

	assign logic_imm = word_t'(i_inst.i.imm12); // zero extended.
	assign shift_imm = word_t'(i_inst.r.rs2);

	// the youngest in-flight write wins, the register file covers the rest.
	function automatic word_t fwd_sel(input logic re, input reg_addr_t addr,
			input word_t rdata, input word_t imm_val,
			input reg_wr_t ex_fwd, input reg_wr_t mem_fwd);
		if (!re)
			return imm_val;
		else if (ex_fwd.we && (ex_fwd.waddr == addr))
			return ex_fwd.wdata;
		else if (mem_fwd.we && (mem_fwd.waddr == addr))
			return mem_fwd.wdata;
		else
			return rdata;
	endfunction

	always_comb begin
		aluop       = ALU_NOP;
		alusel      = SEL_NOP;
		imm         = '0;
		o_re1       = 1'b0;
		o_re2       = 1'b0;
		o_reg_addr1 = i_inst.r.rs1;
		o_reg_addr2 = i_inst.r.rs2;
		case (i_inst.r.opcode)
			OP_OP_IMM: begin
				case (i_inst.r.funct3)
					FUNCT3_XOR: begin
						{aluop, alusel, imm} = {ALU_XOR, SEL_LOGIC, logic_imm};
					end
					FUNCT3_OR: begin
						{aluop, alusel, imm} = {ALU_OR, SEL_LOGIC, logic_imm};
					end
					FUNCT3_AND: begin
						{aluop, alusel, imm} = {ALU_AND, SEL_LOGIC, logic_imm};
					end
					FUNCT3_SLL: begin
						if (i_inst.r.funct7 == '0)
							{aluop, alusel, imm} = {ALU_SLL, SEL_SHIFT, shift_imm};
					end
					FUNCT3_SRL_SRA: begin
						if (i_inst.r.funct7 == FUNCT7_SRLI)
							{aluop, alusel, imm} = {ALU_SRL, SEL_SHIFT, shift_imm};
						else if (i_inst.r.funct7 == FUNCT7_SRAI)
							{aluop, alusel, imm} = {ALU_SRA, SEL_SHIFT, shift_imm};
					end
					default: begin
					end
				endcase
				o_re1 = (alusel != SEL_NOP);
			end
			OP_OP: begin
				if (i_inst.r.funct7 == '0) begin // other funct7 values belong to other extensions.
					case (i_inst.r.funct3)
						FUNCT3_XOR: {aluop, alusel} = {ALU_XOR, SEL_LOGIC};
						FUNCT3_OR:  {aluop, alusel} = {ALU_OR, SEL_LOGIC};
						FUNCT3_AND: {aluop, alusel} = {ALU_AND, SEL_LOGIC};
						default: begin
						end
					endcase
				end
				o_re1 = (alusel != SEL_NOP);
				o_re2 = (alusel != SEL_NOP);
			end
			default: begin
			end
		endcase
		we = (alusel != SEL_NOP) && (i_inst.r.rd != '0);
		if (!we) begin // results aimed at x0 are dropped like a bubble.
			aluop  = ALU_NOP;
			alusel = SEL_NOP;
			o_re1  = 1'b0;
			o_re2  = 1'b0;
		end
	end

	assign o_id_ex = '{
		aluop:     aluop,
		alusel:    alusel,
		opv1:      fwd_sel(o_re1, o_reg_addr1, i_reg_data1, imm, i_ex_fwd, i_mem_fwd),
		opv2:      fwd_sel(o_re2, o_reg_addr2, i_reg_data2, imm, i_ex_fwd, i_mem_fwd),
		reg_waddr: i_inst.r.rd,
		we:        we
	};

endmodule

// File: src/regfile.sv
`timescale 1ns/1ns
`include "core_config.svh"

module regfile (
	input  logic                i_clk,
	input  logic                i_rst,
	input  core_pkg::reg_wr_t   i_wr,
	input  logic                i_re1,
	input  logic                i_re2,
	input  core_pkg::reg_addr_t i_raddr1,
	input  core_pkg::reg_addr_t i_raddr2,
	output core_pkg::word_t     o_rdata1,
	output core_pkg::word_t     o_rdata2
);

	import core_pkg::*;

	word_t regs [`REG_NUM];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < `REG_NUM; i++)
				regs[i] <= '0;
		end else if (i_wr.we && (i_wr.waddr != '0)) begin
			regs[i_wr.waddr] <= i_wr.wdata; // x0 is never written.
		end
	end

	// a write landing this cycle is visible to decode right away.
	function automatic word_t read_port(input logic re, input reg_addr_t addr,
			input word_t stored, input reg_wr_t wr);
		if (!re)
			return '0;
		else if (wr.we && (wr.waddr == addr) && (addr != '0))
			return wr.wdata;
		else
			return stored;
	endfunction

	assign o_rdata1 = read_port(i_re1, i_raddr1, regs[i_raddr1], i_wr);
	assign o_rdata2 = read_port(i_re2, i_raddr2, regs[i_raddr2], i_wr);

endmodule

// File: src/stage_ex.sv
`timescale 1ns/1ns

module stage_ex (
	input  logic              i_clk,
	input  logic              i_rst,
	input  core_pkg::id_ex_t  i_id_ex,
	output core_pkg::reg_wr_t o_ex_res
);

	import core_pkg::*;

	id_ex_t     id_ex_q;
	word_t      result;
	logic [4:0] shamt;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			id_ex_q.we     <= 1'b0;
			id_ex_q.aluop  <= ALU_NOP;
			id_ex_q.alusel <= SEL_NOP;
		end else begin
			id_ex_q <= i_id_ex;
		end
	end

	assign shamt = id_ex_q.opv2[4:0];

	always_comb begin
		result = '0;
		case (id_ex_q.alusel)
			SEL_LOGIC: begin
				case (id_ex_q.aluop)
					ALU_XOR: result = id_ex_q.opv1 ^ id_ex_q.opv2;
					ALU_OR:  result = id_ex_q.opv1 | id_ex_q.opv2;
					ALU_AND: result = id_ex_q.opv1 & id_ex_q.opv2;
					default: result = '0;
				endcase
			end
			SEL_SHIFT: begin
				case (id_ex_q.aluop)
					ALU_SLL: result = id_ex_q.opv1 << shamt;
					ALU_SRL: result = id_ex_q.opv1 >> shamt;
					ALU_SRA: result = word_t'($signed(id_ex_q.opv1) >>> shamt); // sign fill.
					default: result = '0;
				endcase
			end
			default: begin
			end
		endcase
	end

	// this is also the freshest forwarding source seen by decode.
	assign o_ex_res = '{we: id_ex_q.we, waddr: id_ex_q.reg_waddr, wdata: result};

endmodule

// File: src/stage_mem_wb.sv
`timescale 1ns/1ns

module stage_mem_wb (
	input  logic              i_clk,
	input  logic              i_rst,
	input  core_pkg::reg_wr_t i_ex_res,
	output core_pkg::reg_wr_t o_mem_fwd,
	output core_pkg::reg_wr_t o_wb
);

	import core_pkg::*;

	reg_wr_t mem_q;
	reg_wr_t wb_q;

	// there is no data memory, so the result only ages by a cycle here.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			mem_q.we <= 1'b0;
			wb_q.we  <= 1'b0;
		end else begin
			mem_q <= i_ex_res;
			wb_q  <= mem_q;
		end
	end

	assign o_mem_fwd = mem_q;
	assign o_wb      = wb_q; // feeds the register file and the core output.

endmodule

// File: src/riscv_core.sv
`timescale 1ns/1ns
`include "core_config.svh"

module riscv_core (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic [`XLEN-1:0]  i_inst,
	output logic [`XLEN-1:0]  o_pc,
	output core_pkg::reg_wr_t o_wb
);

	import core_pkg::*;

	inst_t     id_inst;
	logic      re1;
	logic      re2;
	reg_addr_t reg_addr1;
	reg_addr_t reg_addr2;
	word_t     reg_data1;
	word_t     reg_data2;
	id_ex_t    id_ex;
	reg_wr_t   ex_res;
	reg_wr_t   mem_fwd;

	stage_if stage_if_inst (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_inst    (i_inst),
		.o_pc      (o_pc),
		.o_id_inst (id_inst)
	);

	stage_id stage_id_inst (
		.i_inst      (id_inst),
		.i_reg_data1 (reg_data1),
		.i_reg_data2 (reg_data2),
		.i_ex_fwd    (ex_res),
		.i_mem_fwd   (mem_fwd),
		.o_re1       (re1),
		.o_re2       (re2),
		.o_reg_addr1 (reg_addr1),
		.o_reg_addr2 (reg_addr2),
		.o_id_ex     (id_ex)
	);

	regfile regfile_inst (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_wr     (o_wb),
		.i_re1    (re1),
		.i_re2    (re2),
		.i_raddr1 (reg_addr1),
		.i_raddr2 (reg_addr2),
		.o_rdata1 (reg_data1),
		.o_rdata2 (reg_data2)
	);

	stage_ex stage_ex_inst (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_id_ex  (id_ex),
		.o_ex_res (ex_res)
	);

	stage_mem_wb stage_mem_wb_inst (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_ex_res  (ex_res),
		.o_mem_fwd (mem_fwd),
		.o_wb      (o_wb)
	);

endmodule

// File: tb/tb_riscv_core.sv
`timescale 1ns/1ns
`include "core_config.svh"

module tb_riscv_core;

	import core_pkg::*;

	localparam int WAIT_LIMIT = 20;

	logic    clk;
	logic    rst;
	word_t   inst;
	word_t   pc;
	reg_wr_t wb;

	word_t   prog[$]; // one word per fetch slot, bubbles past the end.
	reg_wr_t exp_q[$];
	word_t   ref_regs [`REG_NUM];
	word_t   rnd_state = 32'd2;

	riscv_core riscv_core_inst (
		.i_clk  (clk),
		.i_rst  (rst),
		.i_inst (inst),
		.o_pc   (pc),
		.o_wb   (wb)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic word_t fetch_word(input word_t addr);
		word_t idx;
		idx = (addr - `RESET_PC) >> 2;
		if (idx < word_t'(prog.size()))
			return prog[idx];
		else
			return '0;
	endfunction

	initial begin
		rst  = 1'b1;
		inst = '0;
		forever begin
			@(posedge clk);
			#2 inst = fetch_word(pc); // answered within the fetch cycle.
		end
	end

	function automatic word_t xorshift32(input word_t s);
		word_t x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic word_t rand32();
		rnd_state = xorshift32(rnd_state);
		return rnd_state;
	endfunction

	task automatic halt_with_failure();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_wr(input string test, input int idx, input reg_wr_t exp,
			input reg_wr_t act);
		if ((exp.we !== act.we) ||
				(exp.we && ((exp.waddr !== act.waddr) || (exp.wdata !== act.wdata)))) begin
			$display("Error: %s instr %0d expected we=%0b x%0d=%h, actual we=%0b x%0d=%h",
				test, idx, exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
			halt_with_failure();
		end
	endtask

	task automatic check_pc(input string test, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("Error: %s pc expected %h, actual %h", test, exp, act);
			halt_with_failure();
		end
	endtask

	task automatic wait_pc(input string test, input int idx, input word_t target);
		int   n;
		logic found;
		found = 1'b0;
		for (n = 0; (n < WAIT_LIMIT) && !found; n++) begin
			@(negedge clk);
			found = (pc == target);
		end
		if (!found) begin
			$display("timeout in %s: the write-back of instruction %0d never came (pc %h)",
				test, idx, pc);
			halt_with_failure();
		end
	endtask

	task automatic clear_program();
		prog.delete();
		exp_q.delete();
		for (int i = 0; i < `REG_NUM; i++)
			ref_regs[i] = '0;
	endtask

	// appends one word and the write the model expects from it.
	task automatic push_inst(input word_t word, input reg_addr_t rd, input word_t val,
			input logic valid);
		reg_wr_t e;
		prog.push_back(word);
		e.we    = valid && (rd != '0);
		e.waddr = rd;
		e.wdata = val;
		if (e.we)
			ref_regs[rd] = val;
		exp_q.push_back(e);
	endtask

	task automatic emit_raw(input word_t word);
		push_inst(word, 5'd0, '0, 1'b0);
	endtask

	task automatic emit_imm(input alu_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
			input logic [11:0] imm);
		word_t       a;
		word_t       val;
		logic [2:0]  f3;
		logic [11:0] field;
		logic [4:0]  sh;
		a     = ref_regs[rs1];
		sh    = imm[4:0];
		val   = '0;
		f3    = 3'b000;
		field = imm;
		case (op)
			ALU_XOR: begin
				f3  = 3'b100;
				val = a ^ {20'h0, imm};
			end
			ALU_OR: begin
				f3  = 3'b110;
				val = a | {20'h0, imm};
			end
			ALU_AND: begin
				f3  = 3'b111;
				val = a & {20'h0, imm};
			end
			ALU_SLL: begin
				f3    = 3'b001;
				field = {7'b0000000, sh};
				val   = a << sh;
			end
			ALU_SRL: begin
				f3    = 3'b101;
				field = {7'b0000000, sh};
				val   = a >> sh;
			end
			ALU_SRA: begin
				f3    = 3'b101;
				field = {7'b0100000, sh};
				val   = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0); // sign fill.
			end
			default: begin
				$display("test program asked for an immediate op the core lacks");
				halt_with_failure();
			end
		endcase
		push_inst({field, rs1, f3, rd, 7'b0010011}, rd, val, 1'b1);
	endtask

	task automatic emit_reg(input alu_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
			input reg_addr_t rs2);
		word_t      a;
		word_t      b;
		word_t      val;
		logic [2:0] f3;
		a = ref_regs[rs1];
		b = ref_regs[rs2];
		if (op == ALU_XOR) begin
			f3  = 3'b100;
			val = a ^ b;
		end else if (op == ALU_OR) begin
			f3  = 3'b110;
			val = a | b;
		end else begin
			f3  = 3'b111;
			val = a & b;
		end
		push_inst({7'b0000000, rs2, rs1, f3, rd, 7'b0110011}, rd, val, 1'b1);
	endtask

	task automatic reset_dut();
		@(posedge clk);
		#2 rst = 1'b1;
		repeat (10) @(posedge clk);
		#2 rst = 1'b0;
	endtask

	// instruction k is fetched while pc is k*4 and retires four cycles on.
	// the four slots before that show the cleared pipeline registers.
	task automatic run_program(input string test);
		word_t   target;
		reg_wr_t idle;
		idle = '0;
		reset_dut();
		@(negedge clk);
		check_pc(test, `RESET_PC, pc);
		check_wr(test, -4, idle, wb);
		for (int k = -3; k < exp_q.size(); k++) begin
			target = `RESET_PC + word_t'(4 * (k + 4));
			wait_pc(test, k, target);
			if (k < 0)
				check_wr(test, k, idle, wb);
			else
				check_wr(test, k, exp_q[k], wb);
		end
	endtask

	task automatic test_reset_bubbles();
		clear_program();
		for (int i = 0; i < 8; i++)
			emit_raw(32'h0);
		run_program("reset_bubbles");
	endtask

	task automatic test_logic_imm();
		word_t r;
		clear_program();
		emit_imm(ALU_OR, 5'd1, 5'd0, 12'h800); // bit 11 must not sign extend.
		emit_imm(ALU_XOR, 5'd2, 5'd1, 12'hfff);
		emit_imm(ALU_AND, 5'd3, 5'd2, 12'habc);
		for (int i = 0; i < 4; i++) begin
			r = rand32();
			emit_imm(ALU_OR, 5'd4, 5'd0, r[11:0]);
			emit_imm(ALU_XOR, 5'd5, 5'd4, r[23:12]);
			emit_imm(ALU_AND, 5'd6, 5'd5, {r[31:24], r[3:0]});
		end
		run_program("logic_imm");
	endtask

	task automatic test_shift_imm();
		word_t r;
		clear_program();
		emit_imm(ALU_OR, 5'd1, 5'd0, 12'hfff);
		emit_imm(ALU_SLL, 5'd1, 5'd1, 12'd20); // x1 = 0xfff00000.
		emit_imm(ALU_OR, 5'd2, 5'd0, 12'h7a5);
		emit_imm(ALU_SLL, 5'd2, 5'd2, 12'd16);
		for (int i = 0; i < 6; i++) begin
			r = rand32();
			if (i == 4)
				r[4:0] = 5'd0;
			else if (i == 5)
				r[4:0] = 5'd31;
			emit_imm(ALU_SRA, 5'd3, 5'd1, {7'h0, r[4:0]});
			emit_imm(ALU_SRL, 5'd4, 5'd1, {7'h0, r[4:0]});
			emit_imm(ALU_SLL, 5'd5, 5'd1, {7'h0, r[4:0]});
			emit_imm(ALU_SRA, 5'd6, 5'd2, {7'h0, r[4:0]});
			emit_imm(ALU_SRL, 5'd7, 5'd2, {7'h0, r[4:0]});
		end
		run_program("shift_imm");
	endtask

	task automatic test_forwarding();
		word_t r;
		clear_program();
		r = rand32();
		emit_imm(ALU_OR, 5'd1, 5'd0, r[11:0]);
		emit_imm(ALU_SLL, 5'd1, 5'd1, 12'd20);
		emit_imm(ALU_XOR, 5'd1, 5'd1, r[23:12]);
		r = rand32();
		emit_imm(ALU_OR, 5'd2, 5'd0, r[11:0]);
		emit_imm(ALU_SLL, 5'd2, 5'd2, 12'd13);
		emit_imm(ALU_XOR, 5'd2, 5'd2, r[23:12]);
		emit_reg(ALU_XOR, 5'd3, 5'd1, 5'd2); // x2 at distance 1.
		emit_imm(ALU_OR, 5'd9, 5'd0, 12'h0f0);
		emit_reg(ALU_OR, 5'd4, 5'd3, 5'd1); // x3 at distance 2.
		emit_imm(ALU_OR, 5'd10, 5'd0, 12'h00f);
		emit_imm(ALU_OR, 5'd11, 5'd0, 12'h0ff);
		emit_reg(ALU_AND, 5'd5, 5'd4, 5'd3); // x4 at distance 3.
		emit_reg(ALU_XOR, 5'd6, 5'd5, 5'd4);
		emit_reg(ALU_OR, 5'd7, 5'd5, 5'd6);
		emit_imm(ALU_XOR, 5'd8, 5'd0, 12'h001);
		emit_imm(ALU_XOR, 5'd8, 5'd0, 12'h002);
		emit_reg(ALU_OR, 5'd12, 5'd8, 5'd0); // youngest x8 must win.
		run_program("forwarding");
	endtask

	task automatic test_x0_and_undefined();
		clear_program();
		emit_imm(ALU_XOR, 5'd0, 5'd0, 12'h123);
		emit_reg(ALU_OR, 5'd5, 5'd0, 5'd0);
		emit_raw(32'hffff_ffff);
		emit_raw({12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011}); // addi is not in the subset.
		emit_raw({7'b0100001, 5'd3, 5'd0, 3'b101, 5'd2, 7'b0010011});
		emit_raw({7'b0000000, 5'd0, 5'd0, 3'b000, 5'd3, 7'b0110011});
		emit_imm(ALU_XOR, 5'd6, 5'd0, 12'h5a5);
		emit_raw({7'b0000001, 5'd6, 5'd6, 3'b100, 5'd9, 7'b0110011}); // div, not xor.
		emit_raw({7'b0100000, 5'd4, 5'd6, 3'b001, 5'd10, 7'b0010011});
		emit_reg(ALU_OR, 5'd0, 5'd6, 5'd6);
		emit_reg(ALU_XOR, 5'd7, 5'd0, 5'd6);
		emit_reg(ALU_AND, 5'd8, 5'd6, 5'd0);
		run_program("x0_and_undefined");
	endtask

	task automatic test_random_stream();
		word_t      r;
		word_t      s;
		logic [7:0] sel;
		clear_program();
		for (int n = 0; n < 200; n++) begin
			r   = rand32();
			s   = rand32();
			sel = s[7:0] % 8'd9;
			case (sel)
				8'd0: emit_imm(ALU_XOR, r[4:0], r[9:5], r[26:15]);
				8'd1: emit_imm(ALU_OR, r[4:0], r[9:5], r[26:15]);
				8'd2: emit_imm(ALU_AND, r[4:0], r[9:5], r[26:15]);
				8'd3: emit_imm(ALU_SLL, r[4:0], r[9:5], r[26:15]);
				8'd4: emit_imm(ALU_SRL, r[4:0], r[9:5], r[26:15]);
				8'd5: emit_imm(ALU_SRA, r[4:0], r[9:5], r[26:15]);
				8'd6: emit_reg(ALU_XOR, r[4:0], r[9:5], r[14:10]);
				8'd7: emit_reg(ALU_OR, r[4:0], r[9:5], r[14:10]);
				default: emit_reg(ALU_AND, r[4:0], r[9:5], r[14:10]);
			endcase
		end
		run_program("random_stream");
	endtask

	initial begin
		test_reset_bubbles();
		test_logic_imm();
		test_shift_imm();
		test_forwarding();
		test_x0_and_undefined();
		test_random_stream();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: files.f
+incdir+include
src/core_pkg.sv
src/stage_if.sv
src/stage_id.sv
src/regfile.sv
src/stage_ex.sv
src/stage_mem_wb.sv
src/riscv_core.sv
tb/tb_riscv_core.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_riscv_core -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -q "^PASS: all tests$" sim.log; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi
